// File: Makefile
# Verilator build and run of the DMA fill path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_dma_pipeline
RTL_TOP   := dma_pipeline
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, not the exit status of the pipe
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: chunk_addr_looper.sv
/*
 * Issues one DRAM read address per row of a command.
 * A new command is taken only when idle and all tags are drained,
 * so the swap mask never changes under reads in flight.
 * A row count of 0 is handled as a single row.
 */
`timescale 1ns/1ns
`default_nettype none

module chunk_addr_looper (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	// Command
	input  wire                            i_cmd_rdy,
	input  wire [dma_pkg::GADDR_BW-1:0]    i_cmd_gbase,
	input  wire [dma_pkg::ROW_BW-1:0]      i_cmd_nrow,
	input  wire [dma_pkg::GADDR_BW-1:0]    i_cmd_stride,
	input  wire [dma_pkg::HIADDR_BW-1:0]   i_cmd_lbase,
	input  wire [dma_pkg::LANE_BW-1:0]     i_cmd_xor_swap,
	output logic                           o_cmd_ack,
	// DRAM read address
	output logic                           o_dramra_rdy,
	output logic [dma_pkg::GADDR_BW-1:0]   o_dramra,
	input  wire                            i_dramra_ack,
	// Tag FIFO
	output logic                           o_push,
	output logic [dma_pkg::TAG_BW-1:0]     o_push_tag,
	input  wire                            i_full,
	input  wire                            i_empty,
	// Swap mask of the current command
	output logic [dma_pkg::LANE_BW-1:0]    o_xor_swap
);

	//==================================================
	// Loop state
	//==================================================
	logic                           busy;
	logic [dma_pkg::ROW_BW-1:0]     row_cnt;
	logic [dma_pkg::ROW_BW-1:0]     row_last;
	logic [dma_pkg::GADDR_BW-1:0]   stride;
	logic [dma_pkg::HIADDR_BW-1:0]  lrow;
	logic                           addr_fire;
	logic                           is_last;

	// Stall address issue while every tag slot is taken
	assign o_dramra_rdy = busy && !i_full;
	assign addr_fire = o_dramra_rdy && i_dramra_ack;
	assign is_last = row_cnt == row_last;

	// Each issued address leaves its row behind in the tag FIFO
	assign o_push = addr_fire;
	assign o_push_tag = {is_last, lrow};

	// Ack is registered, so rdy has been seen for one cycle before it
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_cmd_ack <= 1'b0;
			busy <= 1'b0;
			row_cnt <= '0;
		end else begin
			o_cmd_ack <= i_cmd_rdy && !o_cmd_ack && !busy && i_empty;
			if (o_cmd_ack) begin
				busy <= 1'b1;
				row_cnt <= '0;
			end else if (addr_fire) begin
				if (is_last) begin
					busy <= 1'b0;
				end
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	//==================================================
	// Address and row accumulators
	//==================================================
	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			o_dramra <= i_cmd_gbase;
			stride <= i_cmd_stride;
			lrow <= i_cmd_lbase;
			o_xor_swap <= i_cmd_xor_swap;
			if (i_cmd_nrow == '0) begin
				row_last <= '0;
			end else begin
				row_last <= i_cmd_nrow - 1'b1;
			end
		end else if (addr_fire) begin
			// Both wrap at their own width
			o_dramra <= o_dramra + stride;
			lrow <= lrow + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: dma_pipeline.sv
/*
 * Fill path top, from one command to a block of SRAM rows.
 * Up to TAG_DEPTH DRAM reads are outstanding at a time.
 * o_done pulses with the last SRAM write of each command.
 */
`timescale 1ns/1ns
`default_nettype none

module dma_pipeline (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	// Command
	input  wire                            i_cmd_rdy,
	input  wire [dma_pkg::GADDR_BW-1:0]    i_cmd_gbase,
	input  wire [dma_pkg::ROW_BW-1:0]      i_cmd_nrow,
	input  wire [dma_pkg::GADDR_BW-1:0]    i_cmd_stride,
	input  wire [dma_pkg::HIADDR_BW-1:0]   i_cmd_lbase,
	input  wire [dma_pkg::LANE_BW-1:0]     i_cmd_xor_swap,
	output logic                           o_cmd_ack,
	// DRAM read address
	output logic                           o_dramra_rdy,
	output logic [dma_pkg::GADDR_BW-1:0]   o_dramra,
	input  wire                            i_dramra_ack,
	// DRAM read data
	input  wire                            i_dramrd_rdy,
	input  wire [dma_pkg::DATA_BW-1:0]     i_dramrd [dma_pkg::N_LANE],
	output logic                           o_dramrd_ack,
	// SRAM write
	output logic                           o_sram_we,
	output logic [dma_pkg::HIADDR_BW-1:0]  o_sram_hiaddr,
	output logic [dma_pkg::DATA_BW-1:0]    o_sram_wdata [dma_pkg::N_LANE],
	output logic                           o_done
);

	logic                         tag_push;
	logic [dma_pkg::TAG_BW-1:0]   tag_in;
	logic                         tag_pop;
	logic [dma_pkg::TAG_BW-1:0]   tag_head;
	logic                         tag_empty;
	logic                         tag_full;
	logic [dma_pkg::LANE_BW-1:0]  xor_swap;

	//==================================================
	// Address side
	//==================================================
	chunk_addr_looper u_looper (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_cmd_rdy      (i_cmd_rdy),
		.i_cmd_gbase    (i_cmd_gbase),
		.i_cmd_nrow     (i_cmd_nrow),
		.i_cmd_stride   (i_cmd_stride),
		.i_cmd_lbase    (i_cmd_lbase),
		.i_cmd_xor_swap (i_cmd_xor_swap),
		.o_cmd_ack      (o_cmd_ack),
		.o_dramra_rdy   (o_dramra_rdy),
		.o_dramra       (o_dramra),
		.i_dramra_ack   (i_dramra_ack),
		.o_push         (tag_push),
		.o_push_tag     (tag_in),
		.i_full         (tag_full),
		.i_empty        (tag_empty),
		.o_xor_swap     (xor_swap)
	);

	// Rows of reads in flight
	tag_fifo #(
		.DEPTH (dma_pkg::TAG_DEPTH)
	) u_tag_fifo (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_push  (tag_push),
		.i_tag   (tag_in),
		.i_pop   (tag_pop),
		.o_tag   (tag_head),
		.o_empty (tag_empty),
		.o_full  (tag_full)
	);

	//==================================================
	// Data side
	//==================================================
	sram_write_collector u_collector (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_dramrd_rdy  (i_dramrd_rdy),
		.i_dramrd      (i_dramrd),
		.o_dramrd_ack  (o_dramrd_ack),
		.i_empty       (tag_empty),
		.i_tag         (tag_head),
		.o_pop         (tag_pop),
		.i_xor_swap    (xor_swap),
		.o_sram_we     (o_sram_we),
		.o_sram_hiaddr (o_sram_hiaddr),
		.o_sram_wdata  (o_sram_wdata),
		.o_done        (o_done)
	);

endmodule

`default_nettype wire

// File: dma_pkg.sv
/*
 * Shared widths and depths of the DRAM-to-SRAM fill path.
 * One DRAM vector fills exactly one SRAM row of N_LANE words.
 * LANE_BW is derived from N_LANE, which must be a power of two.
 */
`default_nettype none

package dma_pkg;

	//==================================================
	// Addressing
	//==================================================
	// Global DRAM address, byte or word granularity is up to the DRAM
	localparam int GADDR_BW = 32;
	// SRAM row address
	localparam int HIADDR_BW = 8;
	// Row count of one command, 1 to 16
	localparam int ROW_BW = 5;

	//==================================================
	// Data
	//==================================================
	localparam int DATA_BW = 16;
	// Words per DRAM vector and per SRAM row
	localparam int N_LANE = 4;
	// Lane index, also the width of the XOR swap mask
	localparam int LANE_BW = $clog2(N_LANE);

	//==================================================
	// Read tags
	//==================================================
	// Reads allowed in flight between looper and collector
	localparam int TAG_DEPTH = 4;
	// Tag is {last, row}
	localparam int TAG_BW = HIADDR_BW + 1;
	// Position of the last-row flag inside a tag
	localparam int TAG_LAST = HIADDR_BW;

endpackage

`default_nettype wire

// File: filelist.f
dma_pkg.sv
tag_fifo.sv
chunk_addr_looper.sv
sram_write_collector.sv
dma_pipeline.sv
tb_dram_model.sv
tb_dma_pipeline.sv

// File: sram_write_collector.sv
/*
 * Takes DRAM vectors in request order and writes them to SRAM.
 * The DRAM must answer in order, as tags are matched by position.
 * The SRAM side has no back-pressure, one write per accepted beat.
 */
`timescale 1ns/1ns
`default_nettype none

module sram_write_collector (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	// DRAM read data
	input  wire                            i_dramrd_rdy,
	input  wire [dma_pkg::DATA_BW-1:0]     i_dramrd [dma_pkg::N_LANE],
	output logic                           o_dramrd_ack,
	// Tag FIFO head
	input  wire                            i_empty,
	input  wire [dma_pkg::TAG_BW-1:0]      i_tag,
	output logic                           o_pop,
	// Bank butterfly key
	input  wire [dma_pkg::LANE_BW-1:0]     i_xor_swap,
	// SRAM write port
	output logic                           o_sram_we,
	output logic [dma_pkg::HIADDR_BW-1:0]  o_sram_hiaddr,
	output logic [dma_pkg::DATA_BW-1:0]    o_sram_wdata [dma_pkg::N_LANE],
	output logic                           o_done
);

	//==================================================
	// Beat acceptance
	//==================================================
	logic                          beat;
	logic                          tag_last;
	logic [dma_pkg::HIADDR_BW-1:0] tag_row;

	// A beat is only taken when its row is known
	assign beat = i_dramrd_rdy && !i_empty;
	assign o_dramrd_ack = beat;
	assign o_pop = beat;

	assign tag_last = i_tag[dma_pkg::TAG_LAST];
	assign tag_row = i_tag[dma_pkg::HIADDR_BW-1:0];

	//==================================================
	// Bank butterfly
	//==================================================
	logic [dma_pkg::DATA_BW-1:0] swz [dma_pkg::N_LANE];

	// Output lane k picks input lane k^swap
	always_comb begin
		for (int k = 0; k < dma_pkg::N_LANE; k++) begin
			swz[k] = i_dramrd[dma_pkg::LANE_BW'(k) ^ i_xor_swap];
		end
	end

	//==================================================
	// SRAM write stage
	//==================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_sram_we <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_sram_we <= beat;
			// Last row of a command closes it
			o_done <= beat && tag_last;
		end
	end

	// Row address and data only matter while we is high
	always_ff @(posedge i_clk) begin
		if (beat) begin
			o_sram_hiaddr <= tag_row;
			for (int k = 0; k < dma_pkg::N_LANE; k++) begin
				o_sram_wdata[k] <= swz[k];
			end
		end
	end

endmodule

`default_nettype wire

// File: tag_fifo.sv
/*
 * Tags of DRAM reads still in flight, oldest at the head.
 * Push to a full FIFO or pop from an empty one is not guarded.
 * A push shows at the head one cycle later.
 */
`timescale 1ns/1ns
`default_nettype none

module tag_fifo #(
	parameter int DEPTH = dma_pkg::TAG_DEPTH
) (
	input  wire                          i_clk,
	input  wire                          i_rst_n,
	input  wire                          i_push,
	input  wire [dma_pkg::TAG_BW-1:0]    i_tag,
	input  wire                          i_pop,
	output logic [dma_pkg::TAG_BW-1:0]   o_tag,
	output logic                         o_empty,
	output logic                         o_full
);

	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BW = $clog2(DEPTH + 1);

	logic [dma_pkg::TAG_BW-1:0] mem [DEPTH];
	logic [PTR_BW-1:0]          wr_ptr;
	logic [PTR_BW-1:0]          rd_ptr;
	logic [CNT_BW-1:0]          count;

	assign o_tag = mem[rd_ptr];
	assign o_empty = count == '0;
	assign o_full = count == CNT_BW'(DEPTH);

	// Storage
	always_ff @(posedge i_clk) begin
		if (i_push) begin
			mem[wr_ptr] <= i_tag;
		end
	end

	//==================================================
	// Pointers and occupancy
	//==================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == PTR_BW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == PTR_BW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			if (i_push && !i_pop) begin
				count <= count + 1'b1;
			end else if (i_pop && !i_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_dma_pipeline.sv
/*
 * Testbench for the fill path with random commands and DRAM delays.
 * Expected addresses and SRAM writes come from a queue model that is
 * filled when a command is accepted. The first mismatch ends the run.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_pipeline;

	localparam int N_CMD = 40;
	localparam int TIMEOUT_CYC = N_CMD * 16 * 12 + 200;
	localparam int VEC_BW = dma_pkg::N_LANE * dma_pkg::DATA_BW;

	logic                           clk;
	logic                           rst_n;
	logic                           cmd_rdy;
	logic [dma_pkg::GADDR_BW-1:0]   cmd_gbase;
	logic [dma_pkg::ROW_BW-1:0]     cmd_nrow;
	logic [dma_pkg::GADDR_BW-1:0]   cmd_stride;
	logic [dma_pkg::HIADDR_BW-1:0]  cmd_lbase;
	logic [dma_pkg::LANE_BW-1:0]    cmd_xor_swap;
	logic                           cmd_ack;
	logic                           dramra_rdy;
	logic [dma_pkg::GADDR_BW-1:0]   dramra;
	logic                           dramra_ack;
	logic                           dramrd_rdy;
	logic [dma_pkg::DATA_BW-1:0]    dramrd [dma_pkg::N_LANE];
	logic                           dramrd_ack;
	logic                           sram_we;
	logic [dma_pkg::HIADDR_BW-1:0]  sram_hiaddr;
	logic [dma_pkg::DATA_BW-1:0]    sram_wdata [dma_pkg::N_LANE];
	logic                           done;

	// Reference model queues, one entry per row
	logic [dma_pkg::GADDR_BW-1:0]   exp_addr [$];
	logic [dma_pkg::HIADDR_BW-1:0]  exp_row [$];
	logic [VEC_BW-1:0]              exp_data [$];
	logic                           exp_last [$];
	int cycle_cnt = 0;
	int done_cnt = 0;
	int open_cmds = 0;
	int in_flight = 0;

	dma_pipeline dut (
		.i_clk (clk), .i_rst_n (rst_n),
		.i_cmd_rdy (cmd_rdy), .i_cmd_gbase (cmd_gbase), .i_cmd_nrow (cmd_nrow),
		.i_cmd_stride (cmd_stride), .i_cmd_lbase (cmd_lbase),
		.i_cmd_xor_swap (cmd_xor_swap), .o_cmd_ack (cmd_ack),
		.o_dramra_rdy (dramra_rdy), .o_dramra (dramra), .i_dramra_ack (dramra_ack),
		.i_dramrd_rdy (dramrd_rdy), .i_dramrd (dramrd), .o_dramrd_ack (dramrd_ack),
		.o_sram_we (sram_we), .o_sram_hiaddr (sram_hiaddr),
		.o_sram_wdata (sram_wdata), .o_done (done)
	);

	tb_dram_model u_dram (
		.i_clk (clk), .i_rst_n (rst_n),
		.i_dramra_rdy (dramra_rdy), .i_dramra (dramra), .o_dramra_ack (dramra_ack),
		.o_dramrd_rdy (dramrd_rdy), .o_dramrd (dramrd), .i_dramrd_ack (dramrd_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//==================================================
	// Checking helpers
	//==================================================
	task automatic stop_on_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("error: time %0t: %s: got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			stop_on_failure();
		end
	endtask

	task automatic fail_with_reason(input string why);
		$display("%s (time %0t)", why, $time);
		stop_on_failure();
	endtask

	// DRAM contents as seen from the outside
	function automatic logic [dma_pkg::DATA_BW-1:0] dram_word(
		input logic [dma_pkg::GADDR_BW-1:0] addr, input int lane);
		logic [dma_pkg::GADDR_BW-1:0] w;
		w = addr * 32'(dma_pkg::N_LANE) + 32'(lane);
		return w[dma_pkg::DATA_BW-1:0];
	endfunction

	// Rows of one accepted command, count 0 runs as one row
	task automatic add_command_model();
		int                           n;
		logic [dma_pkg::GADDR_BW-1:0] a;
		logic [VEC_BW-1:0]            v;
		n = (cmd_nrow == '0) ? 1 : int'(cmd_nrow);
		for (int r = 0; r < n; r++) begin
			a = cmd_gbase + cmd_stride * 32'(r);
			for (int k = 0; k < dma_pkg::N_LANE; k++) begin
				v[k*dma_pkg::DATA_BW +: dma_pkg::DATA_BW] = dram_word(a, k ^ int'(cmd_xor_swap));
			end
			exp_addr.push_back(a);
			exp_row.push_back(cmd_lbase + dma_pkg::HIADDR_BW'(r));
			exp_data.push_back(v);
			exp_last.push_back(r == n - 1);
		end
	endtask

	//==================================================
	// Monitor
	//==================================================
	always @(posedge clk) begin
		logic [VEC_BW-1:0] got;
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
			stop_on_failure();
		end
		if (rst_n) begin
			if (cmd_ack) begin
				if (!cmd_rdy) begin
					fail_with_reason("Command was acknowledged while no command was offered");
				end
				check(64'(open_cmds), 64'd0, "open commands at command ack");
				add_command_model();
				open_cmds++;
			end
			if (dramra_rdy && in_flight >= dma_pkg::TAG_DEPTH) begin
				fail_with_reason("Address offered while all tag slots are in flight");
			end
			if (dramra_rdy && dramra_ack) begin
				if (exp_addr.size() == 0) begin
					fail_with_reason("DRAM address issued with no command rows left");
				end
				check(64'(dramra), 64'(exp_addr.pop_front()), "DRAM read address");
				in_flight++;
			end
			if (dramrd_rdy && dramrd_ack) begin
				in_flight--;
			end
			if (sram_we) begin
				if (exp_row.size() == 0) begin
					fail_with_reason("SRAM write with no expected row left");
				end
				for (int k = 0; k < dma_pkg::N_LANE; k++) begin
					got[k*dma_pkg::DATA_BW +: dma_pkg::DATA_BW] = sram_wdata[k];
				end
				check(64'(sram_hiaddr), 64'(exp_row.pop_front()), "SRAM row address");
				check(64'(got), 64'(exp_data.pop_front()), "SRAM write data");
				check(64'(done), 64'(exp_last.pop_front()), "done flag");
			end else if (done) begin
				fail_with_reason("Done pulsed without an SRAM write");
			end
			if (done) begin
				open_cmds--;
				done_cnt++;
			end
		end
	end

	//==================================================
	// Stimulus
	//==================================================
	initial begin
		int delay;
		void'($urandom(32'h95e15088));
		rst_n = 1'b0;
		// A command offered during reset must not be acked
		cmd_rdy = 1'b1;
		cmd_gbase = '0;
		cmd_nrow = '0;
		cmd_stride = '0;
		cmd_lbase = '0;
		cmd_xor_swap = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		cmd_rdy <= 1'b0;
		@(negedge clk);
		check(64'(cmd_ack), 64'd0, "o_cmd_ack after reset");
		check(64'(dramra_rdy), 64'd0, "o_dramra_rdy after reset");
		check(64'(dramrd_ack), 64'd0, "o_dramrd_ack after reset");
		check(64'(sram_we), 64'd0, "o_sram_we after reset");
		check(64'(done), 64'd0, "o_done after reset");

		for (int n = 0; n < N_CMD; n++) begin
			delay = $urandom_range(3, 0);
			repeat (delay) @(posedge clk);
			@(posedge clk);
			cmd_rdy <= 1'b1;
			cmd_gbase <= $urandom;
			cmd_nrow <= dma_pkg::ROW_BW'($urandom_range(16, 0));
			cmd_stride <= $urandom;
			cmd_lbase <= dma_pkg::HIADDR_BW'($urandom);
			cmd_xor_swap <= dma_pkg::LANE_BW'($urandom);
			// Hold the command until the transfer edge
			@(posedge clk);
			while (cmd_ack !== 1'b1) @(posedge clk);
			cmd_rdy <= 1'b0;
		end

		while (done_cnt < N_CMD) @(posedge clk);
		repeat (10) @(posedge clk);
		if (exp_addr.size() == 0 && exp_row.size() == 0 && open_cmds == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Expected addresses or writes were left over at the end of the run");
			stop_on_failure();
		end
	end

endmodule

`default_nettype wire

// File: tb_dram_model.sv
/*
 * DRAM responder for the fill path testbench, one beat per address.
 * Acks an address after 0 to 3 idle cycles and answers in request order
 * 1 to 6 cycles later. Lane i of address a is the low bits of a*N_LANE+i.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dram_model (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_dramra_rdy,
	input  wire [dma_pkg::GADDR_BW-1:0]    i_dramra,
	output logic                           o_dramra_ack,
	output logic                           o_dramrd_rdy,
	output logic [dma_pkg::DATA_BW-1:0]    o_dramrd [dma_pkg::N_LANE],
	input  wire                            i_dramrd_ack
);

	logic [dma_pkg::GADDR_BW-1:0] pend_addr [$];
	longint                       pend_due [$];

	initial begin
		logic [dma_pkg::GADDR_BW-1:0] word;
		longint                       cycle;
		longint                       last_due;
		longint                       due;
		int                           ra_wait;
		logic                         sent;
		cycle = 0;
		last_due = 0;
		ra_wait = 0;
		o_dramra_ack <= 1'b0;
		o_dramrd_rdy <= 1'b0;
		for (int i = 0; i < dma_pkg::N_LANE; i++) begin
			o_dramrd[i] <= '0;
		end
		forever begin
			@(posedge i_clk);
			cycle++;
			sent = 1'b0;
			if (!i_rst_n) begin
				o_dramra_ack <= 1'b0;
				o_dramrd_rdy <= 1'b0;
				ra_wait = $urandom_range(3, 0);
			end else begin
				//==================================================
				// Address side
				//==================================================
				// Ack lasts one cycle, rdy stays high until it is seen
				if (o_dramra_ack) begin
					o_dramra_ack <= 1'b0;
					due = cycle + longint'($urandom_range(6, 1));
					// Never overtake an older read
					if (due < last_due) begin
						due = last_due;
					end
					last_due = due;
					pend_addr.push_back(i_dramra);
					pend_due.push_back(due);
					ra_wait = $urandom_range(3, 0);
				end else if (i_dramra_rdy) begin
					if (ra_wait == 0) begin
						o_dramra_ack <= 1'b1;
					end else begin
						ra_wait--;
					end
				end

				//==================================================
				// Data side
				//==================================================
				if (o_dramrd_rdy && i_dramrd_ack) begin
					pend_addr.delete(0);
					pend_due.delete(0);
					sent = 1'b1;
				end
				if ((sent || !o_dramrd_rdy) && pend_addr.size() > 0
					&& pend_due[0] <= cycle) begin
					for (int i = 0; i < dma_pkg::N_LANE; i++) begin
						word = pend_addr[0] * 32'(dma_pkg::N_LANE) + 32'(i);
						o_dramrd[i] <= word[dma_pkg::DATA_BW-1:0];
					end
					o_dramrd_rdy <= 1'b1;
				end else if (sent) begin
					o_dramrd_rdy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire
